//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

////////////////////////////////////////
// datapath widths and sizes
////////////////////////////////////////
`define CPU_DATA_WIDTH     32
`define CPU_INST_WIDTH     32
`define CPU_NUM_REGS_LOG2  5
`define CPU_ADDR_WIDTH     8
`define CPU_RAM_DEPTH      256

////////////////////////////////////////
// instruction fields
////////////////////////////////////////
`define CPU_OPCODE_MSB     31
`define CPU_OPCODE_LSB     26
`define CPU_RS_MSB         25
`define CPU_RS_LSB         21
`define CPU_RT_MSB         20
`define CPU_RT_LSB         16
`define CPU_RD_MSB         15
`define CPU_RD_LSB         11
`define CPU_SHAMT_MSB      10
`define CPU_SHAMT_LSB      6
`define CPU_IMM_MSB        15
`define CPU_IMM_LSB        0

`endif

//--- isa_pkg.sv
`include "cpu_params.svh"

package isa_pkg;

  // widths that carry a meaning
  typedef logic [`CPU_DATA_WIDTH-1:0]                 word_t;
  typedef logic [`CPU_INST_WIDTH-1:0]                 inst_t;
  typedef logic [`CPU_NUM_REGS_LOG2-1:0]              reg_addr_t;
  typedef logic [`CPU_IMM_MSB-`CPU_IMM_LSB:0]         imm_t;
  typedef logic [`CPU_SHAMT_MSB-`CPU_SHAMT_LSB:0]     shamt_t;
  typedef logic [`CPU_ADDR_WIDTH-1:0]                 addr_t;

  // any opcode not listed decodes as nop
  typedef enum logic [`CPU_OPCODE_MSB-`CPU_OPCODE_LSB:0] {
    op_nop  = 6'h00,
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_xor  = 6'h05,
    op_slt  = 6'h06,
    op_sll  = 6'h07,
    op_srl  = 6'h08,
    op_addi = 6'h09,
    op_ori  = 6'h0a,
    op_lw   = 6'h0b,
    op_sw   = 6'h0c
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_slt = 3'd5,
    alu_sll = 3'd6,
    alu_srl = 3'd7
  } alu_op_e;

endpackage

//--- pipe_pkg.sv
package pipe_pkg;

  import isa_pkg::*;

  ////////////////////////////////////////
  // stage registers
  ////////////////////////////////////////
  typedef struct packed {
    logic  valid;
    inst_t inst;
  } if_id_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dst;
    word_t     rs_data;
    word_t     rt_data;
    imm_t      imm;
    shamt_t    shamt;
    alu_op_e   alu_op;
    logic      alu_src;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    word_t     result;
    word_t     store_data;
    reg_addr_t dst;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
  } ex_mem_t;

  // writeback record and retirement stream
  typedef struct packed {
    logic      valid;
    reg_addr_t dst;
    word_t     data;
  } wb_t;

  typedef enum logic [1:0] {
    fwd_reg    = 2'd0,
    fwd_ex_mem = 2'd1,
    fwd_mem_wb = 2'd2
  } fwd_sel_e;

endpackage

//--- fetch_stage.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module fetch_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             stall,
  input  isa_pkg::inst_t   instruction,
  output isa_pkg::addr_t   pc,
  output pipe_pkg::if_id_t if_id
);

  import isa_pkg::*;

  addr_t pc_next;

  // one word per cycle
  assign pc_next = pc + `CPU_ADDR_WIDTH'(1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pc_next;
    end
  end

  ////////////////////////////////////////
  // if/id register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id.valid <= 1'b0;
    end else if (!stall) begin
      if_id.valid <= 1'b1;
      if_id.inst  <= instruction;
    end
  end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module decode_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  pipe_pkg::if_id_t  if_id,
  input  pipe_pkg::wb_t     wb,
  output logic              stall,
  output pipe_pkg::id_ex_t  id_ex
);

  import isa_pkg::*;

  opcode_e   opcode;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  imm_t      imm;
  shamt_t    shamt;

  alu_op_e   alu_op;
  logic      alu_src;
  logic      reg_dst;
  logic      mem_read;
  logic      mem_write;
  logic      reg_write;

  word_t     regs [2**`CPU_NUM_REGS_LOG2];
  word_t     rs_data;
  word_t     rt_data;

  assign opcode = opcode_e'(if_id.inst[`CPU_OPCODE_MSB:`CPU_OPCODE_LSB]);
  assign rs     = if_id.inst[`CPU_RS_MSB:`CPU_RS_LSB];
  assign rt     = if_id.inst[`CPU_RT_MSB:`CPU_RT_LSB];
  assign rd     = if_id.inst[`CPU_RD_MSB:`CPU_RD_LSB];
  assign imm    = if_id.inst[`CPU_IMM_MSB:`CPU_IMM_LSB];
  assign shamt  = if_id.inst[`CPU_SHAMT_MSB:`CPU_SHAMT_LSB];

  ////////////////////////////////////////
  // control decode
  ////////////////////////////////////////
  always_comb begin
    alu_src   = 1'b0;
    reg_dst   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    case (opcode)
      op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sll, op_srl: begin
        reg_dst   = 1'b1;
        reg_write = 1'b1;
      end
      op_addi, op_ori: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      op_lw: begin
        alu_src   = 1'b1;
        mem_read  = 1'b1;
        reg_write = 1'b1;
      end
      op_sw: begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
      end
      default: ;
    endcase
  end

  // loads and stores use add for base plus offset
  always_comb begin
    case (opcode)
      op_sub:         alu_op = alu_sub;
      op_and:         alu_op = alu_and;
      op_or, op_ori:  alu_op = alu_or;
      op_xor:         alu_op = alu_xor;
      op_slt:         alu_op = alu_slt;
      op_sll:         alu_op = alu_sll;
      op_srl:         alu_op = alu_srl;
      default:        alu_op = alu_add;
    endcase
  end

  ////////////////////////////////////////
  // register file
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wb.valid) begin
      regs[wb.dst] <= wb.data;
    end
  end

  // r0 reads zero and a same-cycle write is seen at once
  function automatic word_t read_port(input reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (wb.valid && wb.dst == addr) begin
      return wb.data;
    end else begin
      return regs[addr];
    end
  endfunction

  always_comb begin
    rs_data = read_port(rs);
    rt_data = read_port(rt);
  end

  // load in execute feeding the word in decode
  assign stall = id_ex.valid && id_ex.mem_read && if_id.valid &&
                 (id_ex.dst == rs || id_ex.dst == rt);

  ////////////////////////////////////////
  // id/ex register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex.valid     <= 1'b0;
      id_ex.mem_read  <= 1'b0;
      id_ex.mem_write <= 1'b0;
      id_ex.reg_write <= 1'b0;
    end else if (stall || !if_id.valid) begin
      // bubble
      id_ex.valid     <= 1'b0;
      id_ex.mem_read  <= 1'b0;
      id_ex.mem_write <= 1'b0;
      id_ex.reg_write <= 1'b0;
    end else begin
      id_ex.valid     <= 1'b1;
      id_ex.rs        <= rs;
      id_ex.rt        <= rt;
      id_ex.dst       <= reg_dst ? rd : rt;
      id_ex.rs_data   <= rs_data;
      id_ex.rt_data   <= rt_data;
      id_ex.imm       <= imm;
      id_ex.shamt     <= shamt;
      id_ex.alu_op    <= alu_op;
      id_ex.alu_src   <= alu_src;
      id_ex.mem_read  <= mem_read;
      id_ex.mem_write <= mem_write;
      id_ex.reg_write <= reg_write;
    end
  end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  pipe_pkg::id_ex_t  id_ex,
  input  pipe_pkg::wb_t     wb,
  output pipe_pkg::ex_mem_t ex_mem
);

  import isa_pkg::*;
  import pipe_pkg::*;

  fwd_sel_e sel_a;
  fwd_sel_e sel_b;
  word_t    op_a;
  word_t    fwd_b;
  word_t    op_b;
  word_t    result;

  ////////////////////////////////////////
  // forwarding
  ////////////////////////////////////////

  // ex/mem wins over mem/wb and never forwards a load
  function automatic fwd_sel_e pick_fwd(input reg_addr_t src);
    if (ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read &&
        ex_mem.dst != '0 && ex_mem.dst == src) begin
      return fwd_ex_mem;
    end else if (wb.valid && wb.dst != '0 && wb.dst == src) begin
      return fwd_mem_wb;
    end else begin
      return fwd_reg;
    end
  endfunction

  function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val);
    case (sel)
      fwd_ex_mem: return ex_mem.result;
      fwd_mem_wb: return wb.data;
      default:    return reg_val;
    endcase
  endfunction

  always_comb begin
    sel_a = pick_fwd(id_ex.rs);
    sel_b = pick_fwd(id_ex.rt);
    op_a  = fwd_mux(sel_a, id_ex.rs_data);
    fwd_b = fwd_mux(sel_b, id_ex.rt_data);
  end

  ////////////////////////////////////////
  // alu
  ////////////////////////////////////////
  always_comb begin
    // immediate is zero extended
    op_b = id_ex.alu_src ? word_t'(id_ex.imm) : fwd_b;
    case (id_ex.alu_op)
      alu_add: result = op_a + op_b;
      alu_sub: result = op_a - op_b;
      alu_and: result = op_a & op_b;
      alu_or:  result = op_a | op_b;
      alu_xor: result = op_a ^ op_b;
      alu_slt: result = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
      alu_sll: result = fwd_b << id_ex.shamt;
      alu_srl: result = fwd_b >> id_ex.shamt;
      default: result = op_a + op_b;
    endcase
  end

  // ex/mem register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem.valid     <= 1'b0;
      ex_mem.mem_read  <= 1'b0;
      ex_mem.mem_write <= 1'b0;
      ex_mem.reg_write <= 1'b0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.result     <= result;
      ex_mem.store_data <= fwd_b;
      ex_mem.dst        <= id_ex.dst;
      ex_mem.mem_read   <= id_ex.valid && id_ex.mem_read;
      ex_mem.mem_write  <= id_ex.valid && id_ex.mem_write;
      ex_mem.reg_write  <= id_ex.valid && id_ex.reg_write;
    end
  end

endmodule

//--- memory_stage.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module memory_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  pipe_pkg::ex_mem_t ex_mem,
  output pipe_pkg::wb_t     wb
);

  import isa_pkg::*;

  word_t     ram [`CPU_RAM_DEPTH];
  addr_t     ram_addr;
  word_t     load_data;
  word_t     alu_data;
  reg_addr_t wb_dst;
  logic      wb_valid;
  logic      wb_load;

  // word address from the low bits of the alu result
  assign ram_addr = ex_mem.result[`CPU_ADDR_WIDTH-1:0];

  ////////////////////////////////////////
  // data ram and mem/wb payload
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.mem_write) begin
      ram[ram_addr] <= ex_mem.store_data;
    end
    load_data <= ram[ram_addr];
    alu_data  <= ex_mem.result;
    wb_dst    <= ex_mem.dst;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
      wb_load  <= 1'b0;
    end else begin
      // only real register writes retire
      wb_valid <= ex_mem.valid && ex_mem.reg_write && ex_mem.dst != '0;
      wb_load  <= ex_mem.mem_read;
    end
  end

  // writeback select
  assign wb = '{valid: wb_valid,
                dst:   wb_dst,
                data:  wb_load ? load_data : alu_data};

endmodule

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
  input  logic           clk,
  input  logic           rst_n,
  output isa_pkg::addr_t pc,
  input  isa_pkg::inst_t instruction,
  output pipe_pkg::wb_t  retire
);

  import pipe_pkg::*;

  logic    stall;
  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  wb_t     wb;

  fetch_stage i_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .instruction (instruction),
    .pc          (pc),
    .if_id       (if_id)
  );

  decode_stage i_decode (
    .clk   (clk),
    .rst_n (rst_n),
    .if_id (if_id),
    .wb    (wb),
    .stall (stall),
    .id_ex (id_ex)
  );

  execute_stage i_execute (
    .clk    (clk),
    .rst_n  (rst_n),
    .id_ex  (id_ex),
    .wb     (wb),
    .ex_mem (ex_mem)
  );

  memory_stage i_memory (
    .clk    (clk),
    .rst_n  (rst_n),
    .ex_mem (ex_mem),
    .wb     (wb)
  );

  // retirement stream is the writeback record
  assign retire = wb;

endmodule

//--- tb_cpu.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module tb_cpu;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int reset_cycles   = 8;
  localparam int retire_timeout = 50;
  localparam int watch_cycles   = 30;

  logic  clk;
  logic  rst_n;
  inst_t instruction = '0;
  addr_t pc;
  wb_t   retire;

  inst_t     imem [`CPU_RAM_DEPTH];
  reg_addr_t exp_reg [$];
  word_t     exp_data [$];
  int        prog_words;

  cpu_top i_cpu_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc          (pc),
    .instruction (instruction),
    .retire      (retire)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // instruction memory read a little after the edge that moves pc
  always @(posedge clk) begin
    #1;
    instruction = imem[pc];
  end

  ////////////////////////////////////////
  // error handling and compares
  ////////////////////////////////////////
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_reg(input string name, input reg_addr_t expected,
                           input reg_addr_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s register expected r%0d actual r%0d",
                              name, expected, actual));
    end
  endtask

  task automatic check_data(input string name, input word_t expected,
                            input word_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s data expected 0x%08h actual 0x%08h",
                              name, expected, actual));
    end
  endtask

  task automatic check_pc(input string name, input addr_t expected,
                          input addr_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s pc expected 0x%02h actual 0x%02h",
                              name, expected, actual));
    end
  endtask

  ////////////////////////////////////////
  // vectors and waits
  ////////////////////////////////////////
  task automatic load_vectors();
    int        fd;
    int        addr;
    int        n_words;
    logic      at_end;
    string     line;
    inst_t     word;
    reg_addr_t w_reg;
    word_t     w_data;
    for (addr = 0; addr < `CPU_RAM_DEPTH; addr++) begin
      imem[addr] = '0;
    end
    fd = $fopen("cpu_vectors.txt", "r");
    if (fd == 0) begin
      stop_on_error("could not open cpu_vectors.txt for reading");
    end
    n_words = 0;
    at_end  = 1'b0;
    while (!at_end) begin
      if ($fgets(line, fd) == 0) begin
        at_end = 1'b1;
      end else if ($sscanf(line, "I %h", word) == 1) begin
        if (n_words >= `CPU_RAM_DEPTH) begin
          stop_on_error("cpu_vectors.txt holds more program words than memory");
        end
        imem[n_words] = word;
        n_words++;
      end else if ($sscanf(line, "W %h %h", w_reg, w_data) == 2) begin
        exp_reg.push_back(w_reg);
        exp_data.push_back(w_data);
      end
    end
    $fclose(fd);
    prog_words = n_words;
    if (n_words == 0 || exp_reg.size() == 0) begin
      stop_on_error("cpu_vectors.txt has no program or no expected retirements");
    end
  endtask

  // sampled on the falling edge away from the register updates
  task automatic wait_retirement(input int idx);
    int   cycles;
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < retire_timeout) begin
      @(negedge clk);
      seen = retire.valid;
      cycles++;
    end
    if (!seen) begin
      stop_on_error($sformatf("no retirement arrived within %0d cycles for entry %0d",
                              retire_timeout, idx));
    end
  endtask

  initial begin
    int    idx;
    int    cycle;
    string name;
    rst_n = 1'b0;
    load_vectors();

    // retire stays low and pc stays at 0 while reset is held
    for (cycle = 0; cycle < reset_cycles; cycle++) begin
      @(negedge clk);
      if (retire.valid !== 1'b0) begin
        stop_on_error("a retirement appeared while reset was held");
      end
      check_pc("reset", '0, pc);
    end
    @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (idx = 0; idx < exp_reg.size(); idx++) begin
      wait_retirement(idx);
      name = $sformatf("retirement %0d", idx);
      check_reg(name, exp_reg[idx], retire.dst);
      check_data(name, exp_data[idx], retire.data);
    end

    // trailing nops must stay silent
    // pc leads the last program word by its three later stages
    for (cycle = 0; cycle < watch_cycles; cycle++) begin
      @(negedge clk);
      if (retire.valid) begin
        stop_on_error($sformatf("unexpected retirement of r%0d after the last entry",
                                retire.dst));
      end
      check_pc("trailing nops", addr_t'(prog_words + 4 + cycle), pc);
    end

    $display("Test OK");
    $finish;
  end

endmodule

//--- project.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

//--- run.sh
#!/usr/bin/env bash
# build the pipeline testbench with verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_cpu -f project.f -o sim_cpu &&
./obj_dir/sim_cpu ||
{ echo "simulation run failed"; exit 1; }

//--- cpu_vectors.txt
# I <instruction hex>           program words from address 0 upward
# W <register hex> <data hex>   expected retirements in program order
I 24010005  addi r1, r0, 0x0005
I 28028001  ori  r2, r0, 0x8001
I 2403fff0  addi r3, r0, 0xfff0
I 24040003  addi r4, r0, 0x0003
I 08012800  sub  r5, r0, r1
I 04243000  add  r6, r1, r4
I 0c433800  and  r7, r2, r3
I 10224000  or   r8, r1, r2
I 14434800  xor  r9, r2, r3
I 18a15000  slt  r10, r5, r1
I 18255800  slt  r11, r1, r5
I 1c046100  sll  r12, r4, 4
I 20056f00  srl  r13, r5, 28
I 240e0010  addi r14, r0, 0x0010
I 05ce7800  add  r15, r14, r14
I 05ee8000  add  r16, r15, r14
I 0a0e8800  sub  r17, r16, r14
I 12309000  or   r18, r17, r16
I 30290004  sw   r9, 4(r1)
I 3012000a  sw   r18, 10(r0)
I 2c330004  lw   r19, 4(r1)
I 0664a000  add  r20, r19, r4
I 2c15000a  lw   r21, 10(r0)
I 0ab3b000  sub  r22, r21, r19
I 24001234  addi r0, r0, 0x1234
I 04240000  add  r0, r1, r4
I 24170055  addi r23, r0, 0x0055
I 2818abcd  ori  r24, r0, 0xabcd

W 01 00000005
W 02 00008001
W 03 0000fff0
W 04 00000003
W 05 fffffffb
W 06 00000008
W 07 00008000
W 08 00008005
W 09 00007ff1
W 0a 00000001
W 0b 00000000
W 0c 00000030
W 0d 0000000f
W 0e 00000010
W 0f 00000020
W 10 00000030
W 11 00000020
W 12 00000030
W 13 00007ff1
W 14 00007ff4
W 15 00000030
W 16 ffff803f
W 17 00000055
W 18 0000abcd
